// File: hw/stream_monitor_pkg.sv
package stream_monitor_pkg;

  // width of the stream data bus
  localparam int unsigned data_width = 8;

  // longest legal packet in beats
  localparam int unsigned max_packet_beats = 16;

  // beat counter is one bit wider than needed for max_packet_beats
  // so an oversize packet stays visible before the counter saturates
  localparam int unsigned beat_index_width = 5;

  // completed packet counter width
  localparam int unsigned packet_count_width = 16;

  // saturating violation counter width
  localparam int unsigned violation_count_width = 16;

  // counter types shared by tracker and log
  typedef logic [beat_index_width-1:0] beat_index_t;
  typedef logic [packet_count_width-1:0] packet_count_t;
  typedef logic [violation_count_width-1:0] violation_count_t;

  // one clock of the link as the monitor sees it
  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
    logic [data_width-1:0] data;
  } stream_beat_t;

  // one flag per broken rule
  typedef struct packed {
    logic valid_drop;
    logic last_change;
    logic data_change;
    logic oversize;
  } violation_t;

  // where an event happened in the stream
  typedef struct packed {
    packet_count_t packet;
    beat_index_t beat;
  } beat_position_t;

  // registered monitor report
  typedef struct packed {
    violation_t sticky;
    violation_count_t count;
    violation_t first;
    beat_position_t first_position;
    logic any_error;
  } monitor_status_t;

endpackage

// File: hw/stream_tap.sv
`timescale 1ns/1ps

// input side of the monitor
// keeps a one cycle old copy of the link for the stall rule checker
module stream_tap (
  input logic clock,
  input logic reset,
  input stream_monitor_pkg::stream_beat_t link,
  output stream_monitor_pkg::stream_beat_t prev,
  output logic stalled
);

  // beat is offered but the sink is not taking it
  logic stall_now;

  assign stall_now = link.valid & ~link.ready;

  // whole beat is captured every cycle
  always_ff @(posedge clock) begin
    prev <= link;
    stalled <= stall_now;
    if (reset) begin
      // cleared so the first cycle after reset never looks like a stall
      prev.valid <= 1'b0;
      stalled <= 1'b0;
    end
  end

  // prev shows cycle n-1 during cycle n
  // stalled is the valid and not ready state of that same beat
  //
  // a beat that was transferred in cycle n-1 leaves stalled low so the
  // checker lets valid, last and data move freely in cycle n
  //
  // a stall that lasts several cycles keeps stalled high on each of them
  // and every cycle is compared against the one right before it

endmodule

// File: hw/axis_flow_check.sv
`timescale 1ns/1ps

// stall rule checker
// while a beat is waiting for ready it must stay on the link unchanged
module axis_flow_check (
  input logic clock,
  input logic reset,
  input stream_monitor_pkg::stream_beat_t link,
  input stream_monitor_pkg::stream_beat_t prev,
  input logic stalled,
  output stream_monitor_pkg::violation_t stall_violation
);

  // comparison results of this cycle
  stream_monitor_pkg::violation_t check_now;

  // each rule is looked at on its own
  logic valid_dropped;
  logic last_moved;
  logic data_moved;

  // valid went away before the sink took the beat
  // stalled already means the held beat was valid
  assign valid_dropped = ~link.valid;

  // last flipped while the beat was held
  assign last_moved = link.last != prev.last;

  // any data bit changed while the beat was held
  assign data_moved = link.data != prev.data;

  // rules only apply when the previous cycle was a stall
  always_comb begin
    check_now = '0;
    if (stalled) begin
      check_now.valid_drop = valid_dropped;
      check_now.last_change = last_moved;
      check_now.data_change = data_moved;
    end
    // packet length is not this block's job
    check_now.oversize = 1'b0;
  end

  // flags last a single cycle and fall when the link behaves
  always_ff @(posedge clock) begin
    if (reset) begin
      stall_violation <= '0;
    end else begin
      stall_violation <= check_now;
    end
  end

  // comparison at cycle n shows at n+1
  //
  // several flags may come up in the same cycle and the log counts that once
  //
  // a valid drop with different data also raises data_change since
  // the held beat is gone either way
  //
  // no flag is raised while stalled is low, so a new beat after a
  // transfer or after an idle cycle may carry anything
  //
  // the oversize field is tied low here and filled in by the log

endmodule

// File: hw/packet_tracker.sv
`timescale 1ns/1ps

// framing side of the monitor
// counts beats per packet and finished packets, flags packets that run long
module packet_tracker (
  input logic clock,
  input logic reset,
  input stream_monitor_pkg::stream_beat_t link,
  output stream_monitor_pkg::beat_position_t position,
  output logic oversize_violation,
  output stream_monitor_pkg::packet_count_t packets
);

  // running counters for the beat now on the link
  stream_monitor_pkg::beat_index_t beat_count;
  stream_monitor_pkg::packet_count_t packet_count;

  // a beat moves when valid and ready meet
  logic transfer;

  // current beat index is already past the legal length
  logic beyond_max;

  // counter stops at all ones instead of wrapping
  logic beat_saturated;

  assign transfer = link.valid & link.ready;

  assign beyond_max =
    beat_count >= stream_monitor_pkg::beat_index_t'(stream_monitor_pkg::max_packet_beats);

  assign beat_saturated = &beat_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      beat_count <= '0;
      packet_count <= '0;
      position <= '0;
      oversize_violation <= 1'b0;
    end else begin
      // position of cycle n lines up with the stall flags of cycle n
      position.packet <= packet_count;
      position.beat <= beat_count;
      // one pulse per beat beyond max_packet_beats
      oversize_violation <= transfer & beyond_max;
      if (transfer) begin
        if (link.last) begin
          // last closes the packet, next beat is index 0
          beat_count <= '0;
          packet_count <= packet_count + 1'b1;
        end else if (!beat_saturated) begin
          beat_count <= beat_count + 1'b1;
        end
      end
    end
  end

  // finished packets so far
  assign packets = packet_count;

endmodule

// File: hw/violation_log.sv
`timescale 1ns/1ps

// output side of the monitor
// merges all rule flags and keeps the report until the next reset
module violation_log (
  input logic clock,
  input logic reset,
  input stream_monitor_pkg::violation_t stall_violation,
  input logic oversize_violation,
  input stream_monitor_pkg::beat_position_t position,
  output stream_monitor_pkg::monitor_status_t status
);

  // all flags of this cycle in one struct
  stream_monitor_pkg::violation_t merged;

  // at least one rule broken this cycle
  logic any_now;

  // count has reached its top value
  logic count_full;

  // no first record stored yet
  logic first_free;

  // stall flags come in with oversize low, so the oversize bit is taken
  // from the tracker
  always_comb begin
    merged = stall_violation;
    merged.oversize = oversize_violation;
  end

  assign any_now = |merged;
  assign count_full = &status.count;
  assign first_free = ~status.any_error;

  // position arrives on the same cycle as the flags it belongs to
  always_ff @(posedge clock) begin
    if (reset) begin
      status <= '0;
    end else begin
      // flags only ever get set here
      status.sticky <= status.sticky | merged;

      // one step per bad cycle however many flags it holds
      if (any_now && !count_full) begin
        status.count <= status.count + 1'b1;
      end

      // first bad cycle after reset is frozen in the record
      if (any_now && first_free) begin
        status.first <= merged;
        status.first_position <= position;
        status.any_error <= 1'b1;
      end
    end
  end

  // a link event in cycle n lands here at n+2
  //
  // count holds at all ones once full
  //
  // any_error goes up with the first record and
  // guards it from later violations
  //
  // sticky keeps every rule seen since reset, first keeps only the
  // rules of the first bad cycle
  //
  // a fresh reset clears the whole report

endmodule

// File: hw/stream_monitor_top.sv
`timescale 1ns/1ps

// passive stream link monitor
// watches one link and reports stall rule and packet length violations
module stream_monitor_top (
  input logic clock,
  input logic reset,
  input stream_monitor_pkg::stream_beat_t link,
  output stream_monitor_pkg::monitor_status_t status,
  output stream_monitor_pkg::packet_count_t packets
);

  // previous beat and its stall state
  stream_monitor_pkg::stream_beat_t prev;
  logic stalled;

  // stall rule flags, one cycle behind the link
  stream_monitor_pkg::violation_t stall_violation;

  // framing results, one cycle behind the link
  stream_monitor_pkg::beat_position_t position;
  logic oversize_violation;

  // input side
  stream_tap u_tap (
    .clock(clock),
    .reset(reset),
    .link(link),
    .prev(prev),
    .stalled(stalled)
  );

  // stall rule
  axis_flow_check u_flow_check (
    .clock(clock),
    .reset(reset),
    .link(link),
    .prev(prev),
    .stalled(stalled),
    .stall_violation(stall_violation)
  );

  // packet length and counts, sees the raw link directly
  packet_tracker u_tracker (
    .clock(clock),
    .reset(reset),
    .link(link),
    .position(position),
    .oversize_violation(oversize_violation),
    .packets(packets)
  );

  // output side
  violation_log u_log (
    .clock(clock),
    .reset(reset),
    .stall_violation(stall_violation),
    .oversize_violation(oversize_violation),
    .position(position),
    .status(status)
  );

endmodule

// File: bench/stream_monitor_tb.sv
`timescale 1ns/1ps

// directed testbench for the stream link monitor
module stream_monitor_tb;

  localparam time clock_period = 20ns;
  localparam time drive_delay = 2ns;
  localparam int reset_cycles = 8;

  // longest stall inserted before a clean beat
  localparam int max_stall = 2;

  // worst case clocks per test, clean traffic dominates
  localparam int clean_cycles =
    reset_cycles + 5 * stream_monitor_pkg::max_packet_beats * (max_stall + 1) + 7;
  localparam int other_cycles = 2 * reset_cycles + 64;
  localparam time watchdog_time = 4 * (clean_cycles + other_cycles) * clock_period;

  typedef logic [stream_monitor_pkg::data_width-1:0] data_t;

  logic clock;
  logic reset;
  stream_monitor_pkg::stream_beat_t link;
  stream_monitor_pkg::monitor_status_t status;
  stream_monitor_pkg::packet_count_t packets;

  // where the stream stands as seen from the driver side
  stream_monitor_pkg::packet_count_t exp_packets;
  stream_monitor_pkg::beat_index_t exp_beat;

  // report the monitor should hold once its pipeline has settled
  stream_monitor_pkg::monitor_status_t expected_status;

  stream_monitor_top dut (
    .clock(clock),
    .reset(reset),
    .link(link),
    .status(status),
    .packets(packets)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // ends a run that got stuck somewhere
  initial begin
    #(watchdog_time);
    $display("timeout: the tests did not finish within %0t", watchdog_time);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  // inputs change a little after the edge
  task automatic next_cycle;
    @(posedge clock);
    #(drive_delay);
  endtask

  // one beat on the link for one clock, transfers advance the position
  task automatic drive_beat(input logic valid, input logic ready, input logic last,
                            input data_t data);
    link.valid = valid;
    link.ready = ready;
    link.last = last;
    link.data = data;
    next_cycle();
    if (valid && ready) begin
      if (last) begin
        exp_packets = exp_packets + 1'b1;
        exp_beat = '0;
      end else begin
        exp_beat = exp_beat + 1'b1;
      end
    end
  endtask

  // link quiet, nothing offered
  task automatic idle_cycles(input int count);
    link = '0;
    repeat (count) next_cycle();
  endtask

  task automatic apply_reset;
    link = '0;
    reset = 1'b1;
    repeat (reset_cycles) next_cycle();
    reset = 1'b0;
    exp_packets = '0;
    exp_beat = '0;
    expected_status = '0;
  endtask

  function automatic stream_monitor_pkg::violation_t make_violation(
    input logic valid_drop, input logic last_change, input logic data_change,
    input logic oversize);
    stream_monitor_pkg::violation_t flags;
    flags.valid_drop = valid_drop;
    flags.last_change = last_change;
    flags.data_change = data_change;
    flags.oversize = oversize;
    return flags;
  endfunction

  // one bad cycle at the given position
  // sticky collects, count steps once and first is taken only once
  function automatic void expect_violation(input stream_monitor_pkg::violation_t flags,
                                           input stream_monitor_pkg::packet_count_t packet,
                                           input stream_monitor_pkg::beat_index_t beat);
    expected_status.sticky = expected_status.sticky | flags;
    if (expected_status.count != '1) begin
      expected_status.count = expected_status.count + 1'b1;
    end
    if (!expected_status.any_error) begin
      expected_status.first = flags;
      expected_status.first_position.packet = packet;
      expected_status.first_position.beat = beat;
      expected_status.any_error = 1'b1;
    end
  endfunction

  task automatic stop_on_mismatch(input string message);
    $display("FAIL %0t: %s", $time, message);
    $display("Some tests failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_status(input stream_monitor_pkg::monitor_status_t expected,
                              input string label);
    if (status.sticky !== expected.sticky)
      stop_on_mismatch($sformatf("%s sticky %b expected %b",
                                 label, status.sticky, expected.sticky));
    if (status.count !== expected.count)
      stop_on_mismatch($sformatf("%s count %0d expected %0d",
                                 label, status.count, expected.count));
    if (status.first !== expected.first)
      stop_on_mismatch($sformatf("%s first %b expected %b",
                                 label, status.first, expected.first));
    if (status.first_position.packet !== expected.first_position.packet)
      stop_on_mismatch($sformatf("%s first packet %0d expected %0d", label,
                                 status.first_position.packet,
                                 expected.first_position.packet));
    if (status.first_position.beat !== expected.first_position.beat)
      stop_on_mismatch($sformatf("%s first beat %0d expected %0d", label,
                                 status.first_position.beat,
                                 expected.first_position.beat));
    if (status.any_error !== expected.any_error)
      stop_on_mismatch($sformatf("%s any_error %b expected %b",
                                 label, status.any_error, expected.any_error));
  endtask

  task automatic check_count(input stream_monitor_pkg::packet_count_t expected,
                             input string label);
    if (packets !== expected)
      stop_on_mismatch($sformatf("%s packets %0d expected %0d", label, packets, expected));
  endtask

  // five legal packets, stalled beats held steady
  task automatic clean_traffic;
    int unsigned p;
    int unsigned b;
    int unsigned length;
    int unsigned stalls;
    data_t data;
    logic last;
    for (p = 0; p < 5; p++) begin
      length = $urandom_range(stream_monitor_pkg::max_packet_beats, 1);
      for (b = 0; b < length; b++) begin
        data = data_t'($urandom);
        last = (b == length - 1);
        stalls = $urandom_range(max_stall, 0);
        repeat (stalls) drive_beat(1'b1, 1'b0, last, data);
        drive_beat(1'b1, 1'b1, last, data);
      end
      // sometimes a gap between packets
      if ($urandom_range(1, 0) == 1) idle_cycles(1);
    end
    idle_cycles(2);
    check_status(expected_status, "clean traffic");
    check_count(stream_monitor_pkg::packet_count_t'(5), "clean traffic");
  endtask

  // valid falls while a beat waits, mid packet
  task automatic valid_drop;
    data_t data;
    data = data_t'($urandom);
    drive_beat(1'b1, 1'b1, 1'b0, data_t'($urandom));
    drive_beat(1'b1, 1'b1, 1'b0, data_t'($urandom));
    drive_beat(1'b1, 1'b0, 1'b0, data);
    expect_violation(make_violation(1'b1, 1'b0, 1'b0, 1'b0), exp_packets, exp_beat);
    drive_beat(1'b0, 1'b0, 1'b0, data);
    // one cycle on, the log has not seen it yet
    check_status('0, "valid drop early");
    idle_cycles(1);
    check_status(expected_status, "valid drop");
  endtask

  // later data change must not touch the first record
  task automatic sticky_hold;
    data_t data;
    data = data_t'($urandom);
    drive_beat(1'b1, 1'b0, 1'b0, data);
    expect_violation(make_violation(1'b0, 1'b0, 1'b1, 1'b0), exp_packets, exp_beat);
    drive_beat(1'b1, 1'b0, 1'b0, ~data);
    drive_beat(1'b1, 1'b1, 1'b0, ~data);
    check_status(expected_status, "sticky hold");
    apply_reset();
    check_status('0, "after reset");
    check_count('0, "after reset");
  endtask

  // data and last move in the same stalled cycle
  task automatic data_last_change;
    data_t data;
    data = data_t'($urandom);
    drive_beat(1'b1, 1'b1, 1'b0, data_t'($urandom));
    drive_beat(1'b1, 1'b0, 1'b0, data);
    expect_violation(make_violation(1'b0, 1'b1, 1'b1, 1'b0), exp_packets, exp_beat);
    drive_beat(1'b1, 1'b0, 1'b1, ~data);
    drive_beat(1'b1, 1'b1, 1'b1, ~data);
    check_status(expected_status, "data and last change");
    check_count(stream_monitor_pkg::packet_count_t'(1), "data and last change");
  endtask

  // two beats past the legal length, no stalls
  task automatic oversize_packet;
    int unsigned b;
    logic last;
    apply_reset();
    for (b = 0; b < stream_monitor_pkg::max_packet_beats + 2; b++) begin
      last = (b == stream_monitor_pkg::max_packet_beats + 1);
      if (b >= stream_monitor_pkg::max_packet_beats) begin
        expect_violation(make_violation(1'b0, 1'b0, 1'b0, 1'b1), exp_packets, exp_beat);
      end
      // packet still open just before its last beat
      if (last) check_count('0, "oversize before last");
      drive_beat(1'b1, 1'b1, last, data_t'($urandom));
    end
    check_count(stream_monitor_pkg::packet_count_t'(1), "oversize after last");
    idle_cycles(2);
    check_status(expected_status, "oversize");
  endtask

  initial begin
    link = '0;
    reset = 1'b1;
    exp_packets = '0;
    exp_beat = '0;
    expected_status = '0;
    void'($urandom(32'he3e2));
    apply_reset();
    clean_traffic();
    valid_drop();
    sticky_hold();
    data_last_change();
    oversize_packet();
    $display("All tests passed");
    $finish;
  end

endmodule

// File: stream_monitor_top.f
hw/stream_monitor_pkg.sv
hw/stream_tap.sv
hw/axis_flow_check.sv
hw/packet_tracker.sv
hw/violation_log.sv
hw/stream_monitor_top.sv
bench/stream_monitor_tb.sv

// File: Makefile
# Verilator build and run for the stream monitor testbench

VERILATOR ?= verilator
TOP ?= stream_monitor_tb
FILELIST ?= stream_monitor_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
EXTRA_VFLAGS ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
